/* common/inspect_if.sv */
`default_nettype none

`include "inspect_macros.svh"

interface scan_ctrl_if
  import inspect_pkg::*;
();
  logic       start;
  logic       stop;
  pmem_addr_t addr;
  byte_pos_t  len;
  logic       busy;
  logic       done;
  logic       desc_error;

  modport host (output start, stop, addr, len, input busy, done, desc_error);
  modport reader (input start, stop, addr, len, output busy, done, desc_error);
endinterface

interface match_if
  import inspect_pkg::*;
();
  // Byte stream
  logic [7:0]  data;
  logic        last;
  logic        valid;
  logic        ready;
  // Configuration and results
  logic [31:0] pattern;
  logic        clear;
  logic        found;
  byte_pos_t   first_pos;
  byte_pos_t   count;

  modport source (output data, last, valid, input ready);
  modport sink (input data, last, valid, pattern, clear,
                output ready, found, first_pos, count);
  modport control (output pattern, clear, input found, first_pos, count);
endinterface

interface ip_lookup_if
  import inspect_pkg::*;
();
  logic                             start;
  logic [31:0]                      ip;
  logic [`IP_TABLE_DEPTH-1:0][31:0] entry;
  logic [`IP_TABLE_DEPTH-1:0]       mask;
  logic                             done;
  logic                             hit;
  ip_idx_t                          hit_idx;

  modport host (output start, ip, entry, mask, input done, hit, hit_idx);
  modport engine (input start, ip, entry, mask, output done, hit, hit_idx);
endinterface

`default_nettype wire

/* common/inspect_macros.svh */
`ifndef INSPECT_MACROS_SVH
`define INSPECT_MACROS_SVH

// Packet memory word address width
`define PMEM_ADDR_W 10
`define PMEM_DEPTH (1 << `PMEM_ADDR_W)

// Packet length in bytes
`define LEN_W 12

// Address table
`define IP_TABLE_DEPTH 4

`endif

/* common/inspect_pkg.sv */
`default_nettype none

`include "inspect_macros.svh"

package inspect_pkg;

  typedef logic [`PMEM_ADDR_W-1:0] pmem_addr_t;
  typedef logic [`LEN_W-1:0] byte_pos_t;
  typedef logic [$clog2(`IP_TABLE_DEPTH)-1:0] ip_idx_t;

  typedef enum logic [7:0] {
    REG_CTRL        = 8'h00,
    REG_LEN         = 8'h04,
    REG_ADDR        = 8'h08,
    REG_PATTERN     = 8'h0C,
    REG_IP_ADDR     = 8'h10,
    REG_IP_ENTRY0   = 8'h14,
    REG_IP_ENTRY1   = 8'h18,
    REG_IP_ENTRY2   = 8'h1C,
    REG_IP_ENTRY3   = 8'h20,
    REG_IP_MASK     = 8'h24,
    REG_STATUS      = 8'h28,
    REG_MATCH_POS   = 8'h2C,
    REG_MATCH_COUNT = 8'h30,
    REG_IP_HIT_IDX  = 8'h34
  } reg_addr_e;

  // Read back in STATUS, scan_busy at bit 0
  typedef struct packed {
    logic desc_error;
    logic ip_match;
    logic ip_done;
    logic pattern_match;
    logic scan_done;
    logic scan_busy;
  } status_t;

endpackage

`default_nettype wire

/* logic/inspect_regs.sv */
`default_nettype none

`include "inspect_macros.svh"

module inspect_regs
  import inspect_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [7:0]  paddr,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic        pready,
  output logic        pslverr,
  scan_ctrl_if.host   ctrl,
  match_if.control    strm,
  ip_lookup_if.host   lk
);

  logic                             access;
  logic                             wr_en;
  logic                             ctrl_wr;
  logic [31:0]                      rd_data;
  logic                             unmapped;
  logic                             read_only;
  logic                             write_only;
  pmem_addr_t                       addr_q;
  byte_pos_t                        len_q;
  logic [31:0]                      pattern_q;
  logic [31:0]                      ip_q;
  logic [`IP_TABLE_DEPTH-1:0][31:0] entry_q;
  logic [`IP_TABLE_DEPTH-1:0]       mask_q;
  logic                             scan_start_q;
  logic                             scan_stop_q;
  logic                             ip_start_q;
  logic                             scan_done_q;
  logic                             desc_err_q;
  logic                             scan_valid_q;
  status_t                          status;

  // No wait states
  assign access  = psel && penable;
  assign pready  = access;
  assign wr_en   = access && pwrite && !unmapped && !read_only;
  assign ctrl_wr = wr_en && (paddr == REG_CTRL);
  assign pslverr = access && (unmapped || (pwrite ? read_only : write_only));
  assign prdata  = (access && !pwrite) ? rd_data : '0;

  // Match result only counts for a scan that was accepted
  assign status = '{
    desc_error:    desc_err_q,
    ip_match:      lk.hit,
    ip_done:       lk.done,
    pattern_match: strm.found && scan_valid_q,
    scan_done:     scan_done_q,
    scan_busy:     ctrl.busy
  };

  always_comb begin
    unmapped   = 1'b0;
    read_only  = 1'b0;
    write_only = 1'b0;
    rd_data    = '0;
    case (paddr)
      REG_CTRL:        write_only = 1'b1;
      REG_LEN:         rd_data = 32'(len_q);
      REG_ADDR:        rd_data = 32'(addr_q);
      REG_PATTERN:     rd_data = pattern_q;
      REG_IP_ADDR:     rd_data = ip_q;
      REG_IP_ENTRY0:   rd_data = entry_q[0];
      REG_IP_ENTRY1:   rd_data = entry_q[1];
      REG_IP_ENTRY2:   rd_data = entry_q[2];
      REG_IP_ENTRY3:   rd_data = entry_q[3];
      REG_IP_MASK:     rd_data = 32'(mask_q);
      REG_STATUS: begin
        read_only = 1'b1;
        rd_data   = 32'(status);
      end
      REG_MATCH_POS: begin
        read_only = 1'b1;
        rd_data   = 32'(strm.first_pos);
      end
      REG_MATCH_COUNT: begin
        read_only = 1'b1;
        rd_data   = 32'(strm.count);
      end
      REG_IP_HIT_IDX: begin
        read_only = 1'b1;
        rd_data   = 32'(lk.hit_idx);
      end
      default:         unmapped = 1'b1;
    endcase
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      case (paddr)
        REG_LEN:       len_q <= pwdata[`LEN_W-1:0];
        REG_ADDR:      addr_q <= pwdata[`PMEM_ADDR_W-1:0];
        REG_PATTERN:   pattern_q <= pwdata;
        REG_IP_ADDR:   ip_q <= pwdata;
        REG_IP_ENTRY0: entry_q[0] <= pwdata;
        REG_IP_ENTRY1: entry_q[1] <= pwdata;
        REG_IP_ENTRY2: entry_q[2] <= pwdata;
        REG_IP_ENTRY3: entry_q[3] <= pwdata;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      scan_start_q <= 1'b0;
      scan_stop_q  <= 1'b0;
      ip_start_q   <= 1'b0;
      mask_q       <= '0;
      scan_done_q  <= 1'b0;
      desc_err_q   <= 1'b0;
      scan_valid_q <= 1'b0;
    end else begin
      scan_start_q <= ctrl_wr && pwdata[0];
      ip_start_q   <= ctrl_wr && pwdata[1];
      scan_stop_q  <= ctrl_wr && pwdata[4];
      if (wr_en && paddr == REG_IP_MASK) begin
        mask_q <= pwdata[`IP_TABLE_DEPTH-1:0];
      end
      // Sticky, a done pulse wins over a restart
      scan_done_q <= (scan_done_q && !scan_start_q) || ctrl.done;
      desc_err_q  <= (desc_err_q && !scan_start_q && !ip_start_q) || ctrl.desc_error;
      if (ctrl.desc_error) begin
        scan_valid_q <= 1'b0;
      end else if (scan_start_q) begin
        scan_valid_q <= 1'b1;
      end
    end
  end

  assign ctrl.start   = scan_start_q;
  assign ctrl.stop    = scan_stop_q;
  assign ctrl.addr    = addr_q;
  assign ctrl.len     = len_q;
  assign strm.pattern = pattern_q;
  assign strm.clear   = scan_start_q;
  assign lk.start     = ip_start_q;
  assign lk.ip        = ip_q;
  assign lk.entry     = entry_q;
  assign lk.mask      = mask_q;

  a_penable_psel: assert property (@(posedge clk) disable iff (rst) penable |-> psel);

endmodule

`default_nettype wire

/* logic/pkt_inspect_top.sv */
`default_nettype none

module pkt_inspect_top
  import inspect_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  // APB
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [7:0]  paddr,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic        pready,
  output logic        pslverr,
  // Packet memory read port
  output logic        mem_rd_en,
  output pmem_addr_t  mem_rd_addr,
  input  logic [31:0] mem_rd_data
);

  scan_ctrl_if scan_bus ();
  match_if     match_bus ();
  ip_lookup_if lookup_bus ();

  inspect_regs u_regs (
    .clk     (clk),
    .rst     (rst),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .ctrl    (scan_bus),
    .strm    (match_bus),
    .lk      (lookup_bus)
  );

  // Scan path
  pkt_reader u_reader (
    .clk         (clk),
    .rst         (rst),
    .ctrl        (scan_bus),
    .strm        (match_bus),
    .mem_rd_en   (mem_rd_en),
    .mem_rd_addr (mem_rd_addr),
    .mem_rd_data (mem_rd_data)
  );

  byte_matcher u_matcher (
    .clk  (clk),
    .rst  (rst),
    .strm (match_bus)
  );

  ip_lookup u_lookup (
    .clk (clk),
    .rst (rst),
    .lk  (lookup_bus)
  );

endmodule

`default_nettype wire

/* logic/pkt_reader.sv */
`default_nettype none

`include "inspect_macros.svh"

module pkt_reader
  import inspect_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  scan_ctrl_if.reader ctrl,
  match_if.source     strm,
  output logic        mem_rd_en,
  output pmem_addr_t  mem_rd_addr,
  input  logic [31:0] mem_rd_data
);

  logic              busy_q;
  logic              done_q;
  logic              err_q;
  logic              buf_valid;
  logic              rd_pending;
  logic [31:0]       buf_word;
  logic [1:0]        byte_idx;
  pmem_addr_t        rd_addr;
  logic [`LEN_W-2:0] words_left;
  byte_pos_t         bytes_left;
  logic [`LEN_W:0]   len_round;
  logic [`LEN_W-2:0] desc_words;
  logic [`LEN_W:0]   desc_end;
  logic              desc_bad;
  logic              xfer;

  // Word count rounded up, then range check against the memory
  assign len_round  = {1'b0, ctrl.len} + (`LEN_W+1)'(3);
  assign desc_words = len_round[`LEN_W:2];
  assign desc_end   = (`LEN_W+1)'(ctrl.addr) + (`LEN_W+1)'(desc_words);
  assign desc_bad   = (ctrl.len == '0) || (desc_end > (`LEN_W+1)'(`PMEM_DEPTH)) || busy_q;

  assign ctrl.busy       = busy_q;
  assign ctrl.done       = done_q;
  assign ctrl.desc_error = err_q;

  // Fetch only into an empty buffer
  assign mem_rd_en   = busy_q && !buf_valid && !rd_pending && (words_left != '0) && !ctrl.stop;
  assign mem_rd_addr = rd_addr;

  assign strm.valid = buf_valid;
  assign strm.data  = buf_word[8*byte_idx +: 8];
  assign strm.last  = (bytes_left == byte_pos_t'(1));
  assign xfer       = buf_valid && strm.ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      busy_q     <= 1'b0;
      done_q     <= 1'b0;
      err_q      <= 1'b0;
      buf_valid  <= 1'b0;
      rd_pending <= 1'b0;
    end else begin
      done_q <= 1'b0;
      err_q  <= ctrl.start && desc_bad;
      if (busy_q && ctrl.stop) begin
        busy_q     <= 1'b0;
        buf_valid  <= 1'b0;
        rd_pending <= 1'b0;
        done_q     <= 1'b1;
      end else if (ctrl.start && !desc_bad) begin
        busy_q     <= 1'b1;
        buf_valid  <= 1'b0;
        rd_pending <= 1'b0;
      end else begin
        if (mem_rd_en) begin
          rd_pending <= 1'b1;
        end
        if (rd_pending) begin
          rd_pending <= 1'b0;
          buf_valid  <= 1'b1;
        end
        if (xfer && (byte_idx == 2'd3 || strm.last)) begin
          buf_valid <= 1'b0;
        end
        if (xfer && strm.last) begin
          busy_q <= 1'b0;
          done_q <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (ctrl.start && !desc_bad) begin
      rd_addr    <= ctrl.addr;
      words_left <= desc_words;
      bytes_left <= ctrl.len;
    end
    if (mem_rd_en) begin
      rd_addr    <= rd_addr + 1'b1;
      words_left <= words_left - 1'b1;
    end
    // Memory answers one cycle after the request
    if (rd_pending) begin
      buf_word <= mem_rd_data;
      byte_idx <= 2'd0;
    end
    if (xfer) begin
      byte_idx   <= byte_idx + 1'b1;
      bytes_left <= bytes_left - 1'b1;
    end
  end

  a_hold_stream: assert property (@(posedge clk) disable iff (rst)
    strm.valid && !strm.ready |=> !strm.valid || ($stable(strm.data) && $stable(strm.last)));

endmodule

`default_nettype wire

/* match/byte_matcher.sv */
`default_nettype none

module byte_matcher
  import inspect_pkg::*;
(
  input  logic  clk,
  input  logic  rst,
  match_if.sink strm
);

  // Three previous bytes, oldest in the low byte
  logic [23:0] hist;
  byte_pos_t   pos;
  logic        xfer;
  logic        hit;

  assign strm.ready = !strm.clear;
  assign xfer       = strm.valid && strm.ready;

  // Window needs three earlier bytes of this packet
  assign hit = xfer && (pos >= byte_pos_t'(3)) && ({strm.data, hist} == strm.pattern);

  always_ff @(posedge clk) begin
    if (rst || strm.clear) begin
      pos            <= '0;
      strm.found     <= 1'b0;
      strm.first_pos <= '0;
      strm.count     <= '0;
    end else begin
      if (xfer) begin
        pos <= strm.last ? '0 : pos + 1'b1;
      end
      if (hit) begin
        strm.found <= 1'b1;
        strm.count <= strm.count + 1'b1;
        if (!strm.found) begin
          strm.first_pos <= pos - byte_pos_t'(3);
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (xfer) begin
      hist <= {strm.data, hist[23:8]};
    end
  end

  a_count_found: assert property (@(posedge clk) disable iff (rst)
    (strm.count != '0) |-> strm.found);

endmodule

`default_nettype wire

/* match/ip_lookup.sv */
`default_nettype none

`include "inspect_macros.svh"

module ip_lookup
  import inspect_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  ip_lookup_if.engine lk
);

  typedef enum logic {
    IDLE,
    SCAN
  } state_e;

  state_e  state;
  ip_idx_t idx;
  logic    busy;
  logic    entry_hit;

  assign busy = (state == SCAN);

  // Masked entries never hit
  assign entry_hit = lk.mask[idx] && (lk.entry[idx] == lk.ip);

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= IDLE;
      idx        <= '0;
      lk.done    <= 1'b0;
      lk.hit     <= 1'b0;
      lk.hit_idx <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (lk.start) begin
            state   <= SCAN;
            idx     <= '0;
            lk.done <= 1'b0;
            lk.hit  <= 1'b0;
          end
        end
        SCAN: begin
          if (lk.start) begin
            idx <= '0;
          end else if (entry_hit) begin
            state      <= IDLE;
            lk.done    <= 1'b1;
            lk.hit     <= 1'b1;
            lk.hit_idx <= idx;
          end else if (idx == ip_idx_t'(`IP_TABLE_DEPTH-1)) begin
            // Table exhausted, a miss
            state   <= IDLE;
            lk.done <= 1'b1;
          end else begin
            idx <= idx + 1'b1;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  a_busy_done: assert property (@(posedge clk) disable iff (rst) !(busy && lk.done));

endmodule

`default_nettype wire

/* pkt_inspect_top.f */
+incdir+common
common/inspect_pkg.sv
common/inspect_if.sv
logic/pkt_reader.sv
match/byte_matcher.sv
match/ip_lookup.sv
logic/inspect_regs.sv
logic/pkt_inspect_top.sv
tests/pkt_inspect_tb.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
  -f pkt_inspect_top.f --top-module pkt_inspect_tb -o pkt_inspect_sim &&
./obj_dir/pkt_inspect_sim | grep -q "Everything OK" &&
echo "PASS" || { echo "FAIL"; exit 1; }

/* tests/pkt_inspect_tb.sv */
`default_nettype none

`include "inspect_macros.svh"

module pkt_inspect_tb
  import inspect_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam logic [31:0] PAT_A = 32'h3c5a_a5c3;
  localparam logic [31:0] PAT_B = 32'h7e81_18e7;
  localparam logic [31:0] IP_E0 = 32'h0a00_0001;
  localparam logic [31:0] IP_E1 = 32'hc0a8_0101;
  localparam logic [31:0] IP_E2 = 32'hac10_0005;
  localparam logic [31:0] IP_E3 = 32'h0808_0808;

  logic        clk;
  logic        rst;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [7:0]  paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;
  logic        mem_rd_en;
  pmem_addr_t  mem_rd_addr;
  logic [31:0] mem_rd_data;

  logic [31:0] mem [`PMEM_DEPTH];
  int          rd_count = 0;
  int          seed;
  logic        rd_req;
  pmem_addr_t  rd_req_addr;

  pkt_inspect_top UUT (
    .clk         (clk),
    .rst         (rst),
    .psel        (psel),
    .penable     (penable),
    .pwrite      (pwrite),
    .paddr       (paddr),
    .pwdata      (pwdata),
    .prdata      (prdata),
    .pready      (pready),
    .pslverr     (pslverr),
    .mem_rd_en   (mem_rd_en),
    .mem_rd_addr (mem_rd_addr),
    .mem_rd_data (mem_rd_data)
  );

  always #50 clk = ~clk;

  // Packet memory model, data one cycle after the request
  always @(negedge clk) begin
    rd_req      <= mem_rd_en;
    rd_req_addr <= mem_rd_addr;
    if (mem_rd_en) begin
      rd_count <= rd_count + 1;
    end
    if (rd_req) begin
      mem_rd_data <= mem[rd_req_addr];
    end
  end

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Something failed");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("ERR %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_pos(input string name, input byte_pos_t got, input byte_pos_t exp);
    if (got !== exp) begin
      abort_run($sformatf("ERR %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_idx(input string name, input ip_idx_t got, input ip_idx_t exp);
    if (got !== exp) begin
      abort_run($sformatf("ERR %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_status(input status_t got, input status_t exp);
    if (got !== exp) begin
      abort_run($sformatf("ERR STATUS got 0x%h expected 0x%h", got, exp));
    end
  endtask

  function automatic status_t make_status(input logic desc_error, input logic ip_match,
                                          input logic ip_done, input logic pattern_match,
                                          input logic scan_done, input logic scan_busy);
    status_t s;
    s.desc_error    = desc_error;
    s.ip_match      = ip_match;
    s.ip_done       = ip_done;
    s.pattern_match = pattern_match;
    s.scan_done     = scan_done;
    s.scan_busy     = scan_busy;
    return s;
  endfunction

  // Packet byte, low byte of each word first
  function automatic logic [7:0] pkt_byte(input int base, input int off);
    logic [31:0] word;
    word = mem[base + off / 4];
    return word[8 * (off % 4) +: 8];
  endfunction

  task automatic plant_pattern(input int base, input int off, input logic [31:0] pat);
    int idx;
    for (int i = 0; i < 4; i++) begin
      idx = off + i;
      mem[base + idx / 4][8 * (idx % 4) +: 8] = pat[8 * i +: 8];
    end
  endtask

  // Overlapping occurrences in software
  task automatic scan_model(input int base, input int len, input logic [31:0] pat,
                            output int hits, output int first);
    logic [31:0] win;
    hits  = 0;
    first = -1;
    for (int k = 0; k + 4 <= len; k++) begin
      win = {pkt_byte(base, k + 3), pkt_byte(base, k + 2), pkt_byte(base, k + 1),
             pkt_byte(base, k)};
      if (win == pat) begin
        if (hits == 0) begin
          first = k;
        end
        hits++;
      end
    end
  endtask

  task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    #1;
    if (pready !== 1'b0) begin
      abort_run($sformatf("pready was high in the setup phase at offset 0x%h", addr));
    end
    @(negedge clk);
    penable = 1'b1;
    #1;
    if (pready !== 1'b1) begin
      abort_run($sformatf("pready stayed low in the access phase at offset 0x%h", addr));
    end
    rdata = prdata;
    err   = pslverr;
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
    logic [31:0] rd;
    logic        err;
    apb_access(1'b1, addr, data, rd, err);
    if (err) begin
      abort_run($sformatf("Unexpected pslverr on write to offset 0x%h", addr));
    end
  endtask

  task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
    logic err;
    apb_access(1'b0, addr, 32'h0, data, err);
    if (err) begin
      abort_run($sformatf("Unexpected pslverr on read of offset 0x%h", addr));
    end
  endtask

  task automatic apb_expect_error(input logic wr, input logic [7:0] addr, input string what);
    logic [31:0] rd;
    logic        err;
    apb_access(wr, addr, 32'hffff_ffff, rd, err);
    if (!err) begin
      abort_run($sformatf("No pslverr on %s", what));
    end
  endtask

  task automatic wait_status(input logic [5:0] mask, input int limit, input string what,
                             output status_t st);
    logic [31:0] rd;
    logic [5:0]  bits;
    int          polls;
    polls = 0;
    bits  = '0;
    while ((bits & mask) != mask) begin
      if (polls == limit) begin
        abort_run($sformatf("Timed out waiting for %s", what));
      end
      apb_read(REG_STATUS, rd);
      bits = rd[5:0];
      polls++;
    end
    st = status_t'(bits);
  endtask

  task automatic start_scan(input int addr, input int len);
    apb_write(REG_ADDR, 32'(addr));
    apb_write(REG_LEN, 32'(len));
    apb_write(REG_CTRL, 32'h1);
  endtask

  task automatic run_lookup(input logic [31:0] ip, input logic [3:0] mask, output status_t st);
    apb_write(REG_IP_MASK, 32'(mask));
    apb_write(REG_IP_ADDR, ip);
    apb_write(REG_CTRL, 32'h2);
    wait_status(make_status(0, 0, 1, 0, 0, 0), 20, "ip_done", st);
  endtask

  task automatic test_pattern_hit();
    logic [31:0] rd;
    status_t     st;
    int          hits;
    int          first;
    plant_pattern(16, 37, PAT_A);
    scan_model(16, 120, PAT_A, hits, first);
    if (first != 37) begin
      abort_run("Planted pattern is not the first occurrence in the packet");
    end
    apb_write(REG_PATTERN, PAT_A);
    apb_read(REG_PATTERN, rd);
    check_word("PATTERN", rd, PAT_A);
    start_scan(16, 120);
    wait_status(make_status(0, 0, 0, 0, 1, 0), 200, "scan_done", st);
    check_status(st, make_status(0, 0, 0, 1, 1, 0));
    apb_read(REG_MATCH_POS, rd);
    check_pos("MATCH_POS", rd[`LEN_W-1:0], byte_pos_t'(37));
    apb_read(REG_MATCH_COUNT, rd);
    check_pos("MATCH_COUNT", rd[`LEN_W-1:0], byte_pos_t'(hits));
  endtask

  task automatic test_no_match();
    logic [31:0] rd;
    status_t     st;
    int          hits;
    int          first;
    scan_model(300, 100, PAT_B, hits, first);
    if (hits != 0) begin
      abort_run("Packet for the no-match scan already holds the pattern");
    end
    apb_write(REG_PATTERN, PAT_B);
    start_scan(300, 100);
    wait_status(make_status(0, 0, 0, 0, 1, 0), 200, "scan_done", st);
    check_status(st, make_status(0, 0, 0, 0, 1, 0));
    apb_read(REG_MATCH_COUNT, rd);
    check_pos("MATCH_COUNT", rd[`LEN_W-1:0], byte_pos_t'(0));
  endtask

  task automatic test_desc_errors();
    status_t st;
    int      reads_before;
    reads_before = rd_count;
    start_scan(0, 0);
    wait_status(make_status(1, 0, 0, 0, 0, 0), 50, "desc_error on zero length", st);
    check_status(st, make_status(1, 0, 0, 0, 0, 0));
    // Ten words from 1020 run past the end
    start_scan(1020, 40);
    wait_status(make_status(1, 0, 0, 0, 0, 0), 50, "desc_error on range", st);
    check_status(st, make_status(1, 0, 0, 0, 0, 0));
    if (rd_count != reads_before) begin
      abort_run("A rejected descriptor read packet memory");
    end
    start_scan(0, 4000);
    wait_status(make_status(0, 0, 0, 0, 0, 1), 50, "scan_busy", st);
    check_status(st, make_status(0, 0, 0, 0, 0, 1));
    apb_write(REG_CTRL, 32'h1);
    wait_status(make_status(1, 0, 0, 0, 0, 0), 50, "desc_error on start while busy", st);
    check_status(st, make_status(1, 0, 0, 0, 0, 1));
    apb_write(REG_CTRL, 32'h10);
    wait_status(make_status(0, 0, 0, 0, 1, 0), 50, "scan_done after stop", st);
    check_status(st, make_status(1, 0, 0, 0, 1, 0));
  endtask

  task automatic test_stop_scan();
    logic [31:0] rd;
    status_t     st;
    int          hits;
    int          first;
    // Planted copy at byte 101 lies well inside the part scanned before the stop
    scan_model(0, 4000, PAT_A, hits, first);
    apb_write(REG_PATTERN, PAT_A);
    start_scan(0, 4000);
    wait_status(make_status(0, 0, 0, 0, 0, 1), 50, "scan_busy", st);
    repeat (300) @(negedge clk);
    apb_write(REG_CTRL, 32'h10);
    // A full scan would need thousands of cycles
    wait_status(make_status(0, 0, 0, 0, 1, 0), 50, "scan_done after stop", st);
    check_status(st, make_status(0, 0, 0, 1, 1, 0));
    apb_read(REG_MATCH_POS, rd);
    check_pos("MATCH_POS", rd[`LEN_W-1:0], byte_pos_t'(first));
    apb_read(REG_MATCH_COUNT, rd);
    if (rd[`LEN_W-1:0] == 0 || rd[`LEN_W-1:0] > hits) begin
      abort_run($sformatf("ERR MATCH_COUNT got 0x%h outside 0x1 to full packet count 0x%h",
                          rd[`LEN_W-1:0], hits));
    end
  endtask

  task automatic test_ip_lookup();
    logic [31:0] rd;
    status_t     st;
    apb_write(REG_IP_ENTRY0, IP_E0);
    apb_write(REG_IP_ENTRY1, IP_E1);
    apb_write(REG_IP_ENTRY2, IP_E2);
    apb_write(REG_IP_ENTRY3, IP_E3);
    run_lookup(IP_E2, 4'b1111, st);
    check_status(st, make_status(0, 1, 1, 1, 1, 0));
    apb_read(REG_IP_HIT_IDX, rd);
    check_idx("IP_HIT_IDX", ip_idx_t'(rd), ip_idx_t'(2));
    // Entry 1 masked off, same address again in entry 3
    apb_write(REG_IP_ENTRY3, IP_E1);
    run_lookup(IP_E1, 4'b1101, st);
    check_status(st, make_status(0, 1, 1, 1, 1, 0));
    apb_read(REG_IP_HIT_IDX, rd);
    check_idx("IP_HIT_IDX", ip_idx_t'(rd), ip_idx_t'(3));
    run_lookup(32'h0102_0304, 4'b1111, st);
    check_status(st, make_status(0, 0, 1, 1, 1, 0));
  endtask

  task automatic test_bus_errors();
    apb_expect_error(1'b0, 8'h40, "read of unmapped offset 0x40");
    apb_expect_error(1'b1, 8'h3c, "write to unmapped offset 0x3c");
    apb_expect_error(1'b1, REG_STATUS, "write to STATUS");
    apb_expect_error(1'b0, REG_CTRL, "read of CTRL");
  endtask

  initial begin
    clk         = 1'b0;
    rst         = 1'b1;
    psel        = 1'b0;
    penable     = 1'b0;
    pwrite      = 1'b0;
    paddr       = '0;
    pwdata      = '0;
    mem_rd_data = '0;
    rd_req      = 1'b0;
    rd_req_addr = '0;
    seed        = 94279;
    for (int i = 0; i < `PMEM_DEPTH; i++) begin
      mem[i] = $random(seed);
    end
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    test_pattern_hit();
    test_no_match();
    test_desc_errors();
    test_stop_scan();
    test_ip_lookup();
    test_bus_errors();
    $display("Everything OK");
    $finish;
  end

endmodule

`default_nettype wire
